// ==== Bender.yml ====
package:
  name: mipsPipeline

sources:
  - files:
      - mipsPkg.sv
      - stageIf.sv
      - fetchStage.sv
      - decodeStage.sv
      - executeStage.sv
      - memoryStage.sv
      - mipsPipeline.sv
  - target: test
    files:
      - mipsPipeline_assertions.sv
      - mipsMonitor.sv
      - mipsPipeline_tb.sv

// ==== decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage import mipsPkg::*; (
  input  logic                 Clk,
  input  logic                 arstN,
  fetchDecodeIf.sink           fd,
  decodeExecIf.source          de,
  redirectIf.sink              redir,
  input  logic [4:0]           exDest,
  input  logic                 exDestValid,
  input  logic [4:0]           memDest,
  input  logic                 memDestValid,
  input  logic                 commitValid,
  input  logic [4:0]           commitReg,
  input  logic [dataWidth-1:0] commitData
);
  logic [dataWidth-1:0] regFile [32];
  instrU                ins;
  ctrlS                 ctrl;
  logic                 useRs;
  logic                 useRt;
  logic [4:0]           rs;
  logic [4:0]           rt;
  logic [4:0]           dest;
  logic [dataWidth-1:0] rsVal;
  logic [dataWidth-1:0] rtVal;
  logic [dataWidth-1:0] immExt;
  logic [dataWidth-1:0] jumpTarget;
  logic                 rsBusy;
  logic                 rtBusy;
  logic                 canLoad;
  logic                 load;

  assign ins = fd.instr;
  assign rs  = ins.rType.rs;
  assign rt  = ins.rType.rt;

  always_comb begin
    ctrl  = '0;
    useRs = 1'b0;
    useRt = 1'b0;
    dest  = 5'd0;
    case (ins.iType.opcode)
      opSpecial: begin
        useRs = 1'b1;
        useRt = 1'b1;
        dest  = ins.rType.rd;
        ctrl.regWrite = 1'b1;
        case (ins.rType.funct)
          fnAddu: ctrl.aluOp = aluAdd;
          fnSubu: ctrl.aluOp = aluSub;
          fnAnd:  ctrl.aluOp = aluAnd;
          fnOr:   ctrl.aluOp = aluOr;
          fnSlt:  ctrl.aluOp = aluSlt;
          fnSll: begin
            ctrl.aluOp = aluSll;
            useRs = 1'b0;  // Shifts rt only
          end
          default: begin  // Unknown funct runs as a no-op
            ctrl.regWrite = 1'b0;
            useRs = 1'b0;
            useRt = 1'b0;
            dest  = 5'd0;
          end
        endcase
      end
      opAddiu, opAndi, opOri, opLw: begin
        useRs = 1'b1;
        dest  = ins.iType.rt;
        ctrl.aluSrc   = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.memRead  = (ins.iType.opcode == opLw);
        ctrl.zeroExt  = (ins.iType.opcode == opAndi) || (ins.iType.opcode == opOri);
        if (ins.iType.opcode == opAndi) ctrl.aluOp = aluAnd;
        else if (ins.iType.opcode == opOri) ctrl.aluOp = aluOr;
      end
      opLui: begin
        dest = ins.iType.rt;
        ctrl.aluOp    = aluLui;
        ctrl.aluSrc   = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      opSw: begin
        useRs = 1'b1;
        useRt = 1'b1;  // Store data
        ctrl.aluSrc   = 1'b1;
        ctrl.memWrite = 1'b1;
      end
      opBeq, opBne: begin
        useRs = 1'b1;
        useRt = 1'b1;
        ctrl.aluOp    = aluSub;
        ctrl.branch   = 1'b1;
        ctrl.branchNe = (ins.iType.opcode == opBne);
      end
      opJ:     ctrl.jump = 1'b1;
      default: ;  // Outside the subset
    endcase
  end

  assign immExt = ctrl.zeroExt ? {16'b0, ins.iType.imm} : {{16{ins.iType.imm[15]}}, ins.iType.imm};
  assign jumpTarget = {fd.pc4[31:28], ins.iType.rs, ins.iType.rt, ins.iType.imm, 2'b00};

  // Register file, write-through read
  always_comb begin
    rsVal = regFile[rs];
    if (commitValid && commitReg == rs) rsVal = commitData;
    if (rs == 5'd0) rsVal = '0;
    rtVal = regFile[rt];
    if (commitValid && commitReg == rt) rtVal = commitData;
    if (rt == 5'd0) rtVal = '0;
  end

  always_ff @(posedge Clk or negedge arstN) begin
    if (!arstN) begin
      for (int k = 0; k < 32; k++) regFile[k] <= '0;
    end else if (commitValid && commitReg != 5'd0) begin
      regFile[commitReg] <= commitData;
    end
  end

  // Interlock against older writers still in flight
  assign rsBusy = useRs && (rs != 5'd0) && ((exDestValid && exDest == rs) ||
                  (memDestValid && memDest == rs) || (commitValid && commitReg == rs));
  assign rtBusy = useRt && (rt != 5'd0) && ((exDestValid && exDest == rt) ||
                  (memDestValid && memDest == rt) || (commitValid && commitReg == rt));

  assign canLoad  = !de.valid || de.ready;
  assign load     = fd.valid && canLoad && !rsBusy && !rtBusy && !redir.valid;
  assign fd.ready = redir.valid || (canLoad && !rsBusy && !rtBusy);  // Squash consumes

  always_ff @(posedge Clk or negedge arstN) begin
    if (!arstN) de.valid <= 1'b0;
    else if (canLoad) de.valid <= load;
  end

  always_ff @(posedge Clk) begin
    if (load) begin
      de.ctrl   <= ctrl;
      de.pc4    <= fd.pc4;
      de.rsVal  <= rsVal;
      de.rtVal  <= rtVal;
      de.imm    <= immExt;
      de.shamt  <= ins.rType.shamt;
      de.dest   <= dest;
      de.target <= jumpTarget;
    end
  end

endmodule

// ==== executeStage.sv ====
`timescale 1ns/1ps

module executeStage import mipsPkg::*; (
  input  logic        Clk,
  input  logic        arstN,
  decodeExecIf.sink   de,
  execMemIf.source    em,
  redirectIf.source   redir,
  output logic [4:0]  exDest,
  output logic        exDestValid
);
  logic [dataWidth-1:0] opB;
  logic [dataWidth-1:0] aluOut;
  logic [dataWidth-1:0] branchTarget;
  logic                 taken;

  assign opB = de.ctrl.aluSrc ? de.imm : de.rtVal;

  always_comb begin
    case (de.ctrl.aluOp)
      aluAdd:  aluOut = de.rsVal + opB;
      aluSub:  aluOut = de.rsVal - opB;
      aluAnd:  aluOut = de.rsVal & opB;
      aluOr:   aluOut = de.rsVal | opB;
      aluSlt:  aluOut = {31'b0, $signed(de.rsVal) < $signed(opB)};
      aluSll:  aluOut = de.rtVal << de.shamt;
      aluLui:  aluOut = {opB[15:0], 16'b0};
      default: aluOut = '0;
    endcase
  end

  // Branch resolution
  assign branchTarget = de.pc4 + {de.imm[dataWidth-3:0], 2'b00};
  assign taken = de.ctrl.jump ||
                 (de.ctrl.branch && ((de.rsVal == de.rtVal) != de.ctrl.branchNe));

  assign de.ready = !em.valid || em.ready;

  // Raised only in the cycle the branch leaves, so exactly one cycle
  assign redir.valid = de.valid && de.ready && taken;
  assign redir.pc    = de.ctrl.jump ? de.target : branchTarget;

  assign exDest      = de.dest;
  assign exDestValid = de.valid && de.ctrl.regWrite;

  always_ff @(posedge Clk or negedge arstN) begin
    if (!arstN) em.valid <= 1'b0;
    else if (de.ready) em.valid <= de.valid;
  end

  always_ff @(posedge Clk) begin
    if (de.valid && de.ready) begin
      em.ctrl      <= de.ctrl;
      em.result    <= aluOut;    // Address for LW and SW
      em.storeData <= de.rtVal;
      em.dest      <= de.dest;
    end
  end

endmodule

// ==== fetchStage.sv ====
`timescale 1ns/1ps

module fetchStage import mipsPkg::*; #(
  parameter logic [dataWidth-1:0] resetVector = '0
) (
  input  logic                 Clk,
  input  logic                 arstN,
  output logic                 iCyc,
  output logic                 iStb,
  output logic [dataWidth-1:0] iAdr,
  input  logic [dataWidth-1:0] iDatI,
  input  logic                 iAck,
  fetchDecodeIf.source         fd,
  redirectIf.sink              redir
);
  logic [dataWidth-1:0] pc;       // Next fetch address
  logic [dataWidth-1:0] startPc;
  logic                 busOpen;
  logic                 stale;    // Open cycle belongs to a squashed path
  logic                 fdTake;
  logic                 ackNow;
  logic                 startNow;

  assign iCyc = busOpen;
  assign iStb = busOpen;

  assign fdTake   = fd.valid && fd.ready;
  assign ackNow   = busOpen && iAck;
  assign startNow = !busOpen && (!fd.valid || fdTake);  // Register empty after this edge
  assign startPc  = redir.valid ? redir.pc : pc;        // Redirect wins over sequential PC

  always_ff @(posedge Clk or negedge arstN) begin
    if (!arstN) begin
      pc      <= resetVector;
      busOpen <= 1'b0;
      stale   <= 1'b0;
    end else begin
      if (startNow) begin
        busOpen <= 1'b1;
        pc      <= startPc + 32'd4;
      end else begin
        if (redir.valid) pc <= redir.pc;
        if (ackNow) busOpen <= 1'b0;  // Drop on the ack edge
      end
      if (ackNow) stale <= 1'b0;
      else if (busOpen && redir.valid) stale <= 1'b1;  // Let it finish, discard later
    end
  end

  always_ff @(posedge Clk) begin
    if (startNow) iAdr <= {startPc[dataWidth-1:2], 2'b00};  // Word aligned
  end

  // One-deep instruction register
  always_ff @(posedge Clk or negedge arstN) begin
    if (!arstN) fd.valid <= 1'b0;
    else if (ackNow && !stale && !redir.valid) fd.valid <= 1'b1;
    else if (fdTake) fd.valid <= 1'b0;
  end

  always_ff @(posedge Clk) begin
    if (ackNow) begin
      fd.instr <= iDatI;
      fd.pc4   <= iAdr + 32'd4;
    end
  end

endmodule

// ==== memoryStage.sv ====
`timescale 1ns/1ps

module memoryStage import mipsPkg::*; (
  input  logic                 Clk,
  input  logic                 arstN,
  execMemIf.sink               em,
  output logic                 dCyc,
  output logic                 dStb,
  output logic                 dWe,
  output logic [dataWidth-1:0] dAdr,
  output logic [dataWidth-1:0] dDatO,
  input  logic [dataWidth-1:0] dDatI,
  input  logic                 dAck,
  output logic [4:0]           memDest,
  output logic                 memDestValid,
  output logic                 commitValid,
  output logic [4:0]           commitReg,
  output logic [dataWidth-1:0] commitData
);
  logic busOpen;
  logic memOp;    // Valid LW or SW waiting here
  logic take;
  logic startBus;

  assign memOp    = em.valid && (em.ctrl.memRead || em.ctrl.memWrite);
  assign startBus = memOp && !busOpen;
  assign em.ready = !memOp || (busOpen && dAck);  // Held until the slave acks
  assign take     = em.valid && em.ready;

  assign dCyc = busOpen;
  assign dStb = busOpen;

  assign memDest      = em.dest;
  assign memDestValid = em.valid && em.ctrl.regWrite;

  always_ff @(posedge Clk or negedge arstN) begin
    if (!arstN) begin
      busOpen     <= 1'b0;
      dWe         <= 1'b0;
      commitValid <= 1'b0;
    end else begin
      if (busOpen && dAck) begin
        busOpen <= 1'b0;  // Cycle ends on the ack edge
        dWe     <= 1'b0;
      end else if (startBus) begin
        busOpen <= 1'b1;
        dWe     <= em.ctrl.memWrite;
      end
      // Register 0 never commits
      commitValid <= take && em.ctrl.regWrite && (em.dest != 5'd0);
    end
  end

  always_ff @(posedge Clk) begin
    if (startBus) begin
      dAdr  <= {em.result[dataWidth-1:2], 2'b00};
      dDatO <= em.storeData;
    end
    if (take) begin
      commitReg  <= em.dest;
      commitData <= em.ctrl.memRead ? dDatI : em.result;  // Load data sampled with ack
    end
  end

endmodule

// ==== mipsMonitor.sv ====
`timescale 1ns/1ps

module mipsMonitor import mipsPkg::*; #(
  parameter logic [dataWidth-1:0] resetVector = '0,
  parameter int commitTarget = 400
) (
  input  logic                 Clk,
  input  logic                 arstN,
  input  logic                 iCyc,
  input  logic                 iStb,
  input  logic [dataWidth-1:0] iAdr,
  input  logic                 dCyc,
  input  logic                 dStb,
  input  logic                 dWe,
  input  logic [dataWidth-1:0] dAdr,
  input  logic [dataWidth-1:0] dDatO,
  input  logic                 dAck,
  input  logic                 commitValid,
  input  logic [4:0]           commitReg,
  input  logic [dataWidth-1:0] commitData,
  input  logic [dataWidth-1:0] progMem [256],
  input  logic [dataWidth-1:0] dataInit [64],
  input  int                   assertFails,
  output logic                 done,
  output int                   errorCount,
  output int                   commitCount
);
  logic [dataWidth-1:0] regs [32];  // Architectural state of the model
  logic [dataWidth-1:0] mem [64];
  logic [dataWidth-1:0] pc;
  logic [4:0]           recent [3];  // Dests of the last three instructions
  bit                   expNone;     // Model ran dry
  bit                   expStore;
  logic [4:0]           expReg;
  logic [dataWidth-1:0] expVal;
  logic [dataWidth-1:0] expAddr;
  int                   expCls;      // Test 2 for ALU, 3 for memory
  bit                   expTaken;    // Taken branch or jump since last event
  bit                   expDep;
  int                   checks [1:6];
  int                   fails [1:6];
  int                   testsPassed;
  int                   testsFailed;
  bit                   firstFetch;

  task automatic resetModel();
    for (int k = 0; k < 32; k++) regs[k] = '0;
    mem       = dataInit;
    pc        = resetVector;
    recent[0] = 5'd0;
    recent[1] = 5'd0;
    recent[2] = 5'd0;
  endtask

  // Step the ISA model up to its next register write or store
  task automatic nextEvent();
    instrU                ins;
    logic [dataWidth-1:0] rsV;
    logic [dataWidth-1:0] rtV;
    logic [dataWidth-1:0] sImm;
    logic [dataWidth-1:0] pc4;
    logic [dataWidth-1:0] addr;
    logic [dataWidth-1:0] res;
    logic [4:0]           wr;
    bit                   useRs;
    bit                   useRt;
    bit                   isStore;
    bit                   dep;
    expNone  = 1'b1;
    expTaken = 1'b0;
    for (int steps = 0; steps < 1024 && expNone; steps++) begin
      ins     = progMem[pc[9:2]];
      pc4     = pc + 32'd4;
      rsV     = regs[ins.iType.rs];
      rtV     = regs[ins.iType.rt];
      sImm    = {{16{ins.iType.imm[15]}}, ins.iType.imm};
      wr      = 5'd0;
      res     = '0;
      addr    = '0;
      useRs   = 1'b1;
      useRt   = 1'b0;
      isStore = 1'b0;
      expCls  = 2;
      pc      = pc4;
      case (ins.iType.opcode)
        opSpecial: begin
          wr    = ins.rType.rd;
          useRt = 1'b1;
          case (ins.rType.funct)
            fnAddu: res = rsV + rtV;
            fnSubu: res = rsV - rtV;
            fnAnd:  res = rsV & rtV;
            fnOr:   res = rsV | rtV;
            fnSlt:  res = ($signed(rsV) < $signed(rtV)) ? 32'd1 : 32'd0;
            fnSll: begin
              res   = rtV << ins.rType.shamt;
              useRs = 1'b0;
            end
            default: begin  // No-op
              wr    = 5'd0;
              useRs = 1'b0;
              useRt = 1'b0;
            end
          endcase
        end
        opAddiu: begin
          wr  = ins.iType.rt;
          res = rsV + sImm;
        end
        opAndi: begin
          wr  = ins.iType.rt;
          res = rsV & {16'b0, ins.iType.imm};
        end
        opOri: begin
          wr  = ins.iType.rt;
          res = rsV | {16'b0, ins.iType.imm};
        end
        opLui: begin
          wr    = ins.iType.rt;
          res   = {ins.iType.imm, 16'b0};
          useRs = 1'b0;
        end
        opLw: begin
          wr     = ins.iType.rt;
          addr   = rsV + sImm;
          res    = mem[addr[7:2]];
          expCls = 3;
        end
        opSw: begin
          addr    = rsV + sImm;
          useRt   = 1'b1;
          isStore = 1'b1;
          mem[addr[7:2]] = rtV;
          expCls  = 3;
        end
        opBeq, opBne: begin
          useRt = 1'b1;
          if ((rsV == rtV) == (ins.iType.opcode == opBeq)) begin
            pc       = pc4 + (sImm << 2);
            expTaken = 1'b1;
          end
        end
        opJ: begin
          pc       = {pc4[31:28], ins.iType.rs, ins.iType.rt, ins.iType.imm, 2'b00};
          expTaken = 1'b1;
          useRs    = 1'b0;
        end
        default: useRs = 1'b0;
      endcase
      dep = (useRs && ins.iType.rs != 5'd0 && (ins.iType.rs == recent[0] ||
             ins.iType.rs == recent[1] || ins.iType.rs == recent[2])) ||
            (useRt && ins.iType.rt != 5'd0 && (ins.iType.rt == recent[0] ||
             ins.iType.rt == recent[1] || ins.iType.rt == recent[2]));
      recent[2] = recent[1];
      recent[1] = recent[0];
      recent[0] = wr;
      if (wr != 5'd0) regs[wr] = res;
      if (wr != 5'd0 || isStore) begin
        expNone  = 1'b0;
        expStore = isStore;
        expReg   = wr;
        expVal   = isStore ? rtV : res;
        expAddr  = {addr[31:2], 2'b00};
        expDep   = dep;
      end
    end
  endtask

  // Book one comparison against every test it touches
  task automatic record(bit ok);
    checks[expCls]++;
    checks[6]++;
    if (expTaken) checks[4]++;
    if (expDep) checks[5]++;
    if (!ok) begin
      fails[expCls]++;
      fails[6]++;
      if (expTaken) fails[4]++;
      if (expDep) fails[5]++;
      errorCount++;
    end
  endtask

  task automatic handleCommit();
    bit ok;
    ok = 1'b1;
    commitCount++;
    nextEvent();
    if (expNone) begin
      $display("Commit of r%0d at %0t ns but the model has nothing left to commit",
               commitReg, $time);
      ok = 1'b0;
    end else if (expStore) begin
      $display("Commit of r%0d at %0t ns where the model expected a store to %h",
               commitReg, $time, expAddr);
      ok = 1'b0;
    end else begin
      if (commitReg !== expReg) begin
        $display("ERR %0t ns commitReg expected %0d got %0d", $time, expReg, commitReg);
        ok = 1'b0;
      end
      if (commitData !== expVal) begin
        $display("ERR %0t ns commitData expected %h got %h", $time, expVal, commitData);
        ok = 1'b0;
      end
    end
    record(ok);
  endtask

  task automatic handleStore();
    bit ok;
    ok = 1'b1;
    nextEvent();
    if (expNone || !expStore) begin
      $display("Store to %h at %0t ns where the model expected a register write",
               dAdr, $time);
      ok = 1'b0;
    end else begin
      if (dAdr !== expAddr) begin
        $display("ERR %0t ns dAdr expected %h got %h", $time, expAddr, dAdr);
        ok = 1'b0;
      end
      if (dDatO !== expVal) begin
        $display("ERR %0t ns dDatO expected %h got %h", $time, expVal, dDatO);
        ok = 1'b0;
      end
    end
    record(ok);
  endtask

  task automatic printTest(int n);
    string name;
    case (n)
      1: name = "reset state and first fetch";
      2: name = "ALU and immediate commits";
      3: name = "loads and stores";
      4: name = "taken branches and jumps";
      5: name = "dependent instructions";
      default: name = "random bus delays";
    endcase
    if (checks[n] == 0) begin
      $display("Test %0d %s: fail, no events exercised", n, name);
      testsFailed++;
      errorCount++;
    end else if (fails[n] != 0) begin
      $display("Test %0d %s: fail, %0d of %0d checks wrong", n, name, fails[n], checks[n]);
      testsFailed++;
    end else begin
      $display("Test %0d %s: pass, %0d checks", n, name, checks[n]);
      testsPassed++;
    end
  endtask

  always @(posedge Clk) begin
    if (!arstN) begin
      resetModel();
      done = 1'b0;
      checks[1]++;
      if ({iCyc, iStb, dCyc, dStb, dWe, commitValid} !== 6'b0) begin
        $display("Strobe or commitValid not low during reset at %0t ns", $time);
        fails[1]++;
        errorCount++;
      end
    end else if (!done) begin
      if (!firstFetch && iCyc) begin
        firstFetch = 1'b1;
        checks[1]++;
        if (iAdr !== resetVector) begin
          $display("ERR %0t ns iAdr expected %h got %h", $time, resetVector, iAdr);
          fails[1]++;
          errorCount++;
        end
        printTest(1);
      end
      if (commitValid) handleCommit();  // Older than a store acked on the same edge
      if (dCyc && dStb && dWe && dAck) handleStore();
      if (commitCount >= commitTarget) begin
        fails[6]   += assertFails;  // Bus protocol failures
        errorCount += assertFails;
        for (int n = 2; n <= 6; n++) printTest(n);
        $display("Tests run 6, passed %0d, failed %0d; %0d commits, %0d errors",
                 testsPassed, testsFailed, commitCount, errorCount);
        done = 1'b1;
      end
    end
  end

endmodule

// ==== mipsPipeline.f ====
mipsPkg.sv
stageIf.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memoryStage.sv
mipsPipeline.sv
mipsPipeline_assertions.sv
mipsMonitor.sv
mipsPipeline_tb.sv

// ==== mipsPipeline.sv ====
`timescale 1ns/1ps

module mipsPipeline import mipsPkg::*; #(
  parameter logic [dataWidth-1:0] resetVector = '0
) (
  input  logic                 Clk,
  input  logic                 arstN,
  // Instruction bus, read only
  output logic                 iCyc,
  output logic                 iStb,
  output logic [dataWidth-1:0] iAdr,
  input  logic [dataWidth-1:0] iDatI,
  input  logic                 iAck,
  // Data bus
  output logic                 dCyc,
  output logic                 dStb,
  output logic                 dWe,
  output logic [dataWidth-1:0] dAdr,
  output logic [dataWidth-1:0] dDatO,
  input  logic [dataWidth-1:0] dDatI,
  input  logic                 dAck,
  // Register writes in program order
  output logic                 commitValid,
  output logic [4:0]           commitReg,
  output logic [dataWidth-1:0] commitData
);
  fetchDecodeIf fdLink ();
  decodeExecIf  deLink ();
  execMemIf     emLink ();
  redirectIf    redirLink ();

  logic [4:0] exDest;        // Interlock feedback
  logic       exDestValid;
  logic [4:0] memDest;
  logic       memDestValid;

  fetchStage #(.resetVector(resetVector)) fetch (
    .Clk(Clk), .arstN(arstN),
    .iCyc(iCyc), .iStb(iStb), .iAdr(iAdr), .iDatI(iDatI), .iAck(iAck),
    .fd(fdLink.source), .redir(redirLink.sink)
  );

  decodeStage decode (
    .Clk(Clk), .arstN(arstN),
    .fd(fdLink.sink), .de(deLink.source), .redir(redirLink.sink),
    .exDest(exDest), .exDestValid(exDestValid),
    .memDest(memDest), .memDestValid(memDestValid),
    .commitValid(commitValid), .commitReg(commitReg), .commitData(commitData)
  );

  executeStage execute (
    .Clk(Clk), .arstN(arstN),
    .de(deLink.sink), .em(emLink.source), .redir(redirLink.source),
    .exDest(exDest), .exDestValid(exDestValid)
  );

  memoryStage memory (
    .Clk(Clk), .arstN(arstN), .em(emLink.sink),
    .dCyc(dCyc), .dStb(dStb), .dWe(dWe), .dAdr(dAdr), .dDatO(dDatO),
    .dDatI(dDatI), .dAck(dAck),
    .memDest(memDest), .memDestValid(memDestValid),
    .commitValid(commitValid), .commitReg(commitReg), .commitData(commitData)
  );

endmodule

// ==== mipsPipeline_assertions.sv ====
`timescale 1ns/1ps

module mipsPipeline_assertions import mipsPkg::*; (
  input logic                 Clk,
  input logic                 arstN,
  input logic                 iCyc,
  input logic                 iStb,
  input logic [dataWidth-1:0] iAdr,
  input logic                 iAck,
  input logic                 dCyc,
  input logic                 dStb,
  input logic                 dWe,
  input logic [dataWidth-1:0] dAdr,
  input logic [dataWidth-1:0] dDatO,
  input logic                 dAck,
  input logic                 commitValid,
  input logic [4:0]           commitReg
);
  int assertFails = 0;  // Failure tally

  iStbInCyc: assert property (@(posedge Clk) disable iff (!arstN) iStb |-> iCyc)
    else begin
      $error("iStb high outside a bus cycle");
      assertFails++;
    end

  dStbInCyc: assert property (@(posedge Clk) disable iff (!arstN) dStb |-> dCyc)
    else begin
      $error("dStb high outside a bus cycle");
      assertFails++;
    end

  // Address held until ack
  iHold: assert property (@(posedge Clk) disable iff (!arstN)
                          (iStb && !iAck) |=> (iStb && $stable(iAdr) && iAdr[1:0] == 2'b00))
    else begin
      $error("Instruction bus request changed before iAck");
      assertFails++;
    end

  dHold: assert property (@(posedge Clk) disable iff (!arstN)
                          (dStb && !dAck) |=> (dStb && $stable(dAdr) && $stable(dWe) &&
                                               $stable(dDatO)))
    else begin
      $error("Data bus request changed before dAck");
      assertFails++;
    end

  commitNotZero: assert property (@(posedge Clk) disable iff (!arstN)
                                  commitValid |-> commitReg != 5'd0)
    else begin
      $error("Commit to register 0");
      assertFails++;
    end

endmodule

// ==== mipsPipeline_tb.sv ====
`timescale 1ns/1ps

module mipsPipeline_tb import mipsPkg::*; ();
  localparam logic [dataWidth-1:0] resetVector = 32'h0000_0040;
  localparam int commitTarget = 400;
  localparam int clkPeriod    = 10;
  localparam int timeoutNs    = commitTarget * 40 * clkPeriod;  // 40 cycles per commit worst case

  logic                 Clk;
  logic                 arstN;
  logic                 iCyc;
  logic                 iStb;
  logic [dataWidth-1:0] iAdr;
  logic [dataWidth-1:0] iDatI;
  logic                 iAck;
  logic                 dCyc;
  logic                 dStb;
  logic                 dWe;
  logic [dataWidth-1:0] dAdr;
  logic [dataWidth-1:0] dDatO;
  logic [dataWidth-1:0] dDatI;
  logic                 dAck;
  logic                 commitValid;
  logic [4:0]           commitReg;
  logic [dataWidth-1:0] commitData;

  logic [dataWidth-1:0] progMem [256];  // Ring of 256 words, indexed by iAdr[9:2]
  logic [dataWidth-1:0] dataMem [64];   // 64-word data window
  int                   iWait;
  int                   dWait;
  bit                   iBusy;          // Wait count already drawn for this cycle
  bit                   dBusy;
  logic                 done;
  int                   errorCount;
  int                   commitCount;

  mipsPipeline #(.resetVector(resetVector)) uut (
    .Clk(Clk), .arstN(arstN),
    .iCyc(iCyc), .iStb(iStb), .iAdr(iAdr), .iDatI(iDatI), .iAck(iAck),
    .dCyc(dCyc), .dStb(dStb), .dWe(dWe), .dAdr(dAdr), .dDatO(dDatO),
    .dDatI(dDatI), .dAck(dAck),
    .commitValid(commitValid), .commitReg(commitReg), .commitData(commitData)
  );

  bind mipsPipeline mipsPipeline_assertions busChecks (.*);

  mipsMonitor #(.resetVector(resetVector), .commitTarget(commitTarget)) monitor (
    .Clk(Clk), .arstN(arstN),
    .iCyc(iCyc), .iStb(iStb), .iAdr(iAdr),
    .dCyc(dCyc), .dStb(dStb), .dWe(dWe), .dAdr(dAdr), .dDatO(dDatO), .dAck(dAck),
    .commitValid(commitValid), .commitReg(commitReg), .commitData(commitData),
    .progMem(progMem), .dataInit(dataMem),
    .assertFails(uut.busChecks.assertFails),
    .done(done), .errorCount(errorCount), .commitCount(commitCount)
  );

  always #(clkPeriod / 2) Clk = ~Clk;

  // One random instruction, forward control flow only
  function automatic logic [dataWidth-1:0] randomInstr(int idx);
    instrU      w;
    int         pick;
    int         tgt;
    logic [4:0] ra;
    logic [4:0] rb;
    logic [4:0] rc;
    w    = '0;
    pick = $urandom_range(0, 15);
    ra   = 5'($urandom_range(0, 7));  // Few registers, many dependencies
    rb   = 5'($urandom_range(0, 7));
    rc   = 5'($urandom_range(0, 7));
    if (pick <= 5) begin
      w.rType.opcode = opSpecial;
      w.rType.rs     = ra;
      w.rType.rt     = rb;
      w.rType.rd     = rc;
      case (pick)
        0: w.rType.funct = fnAddu;
        1: w.rType.funct = fnSubu;
        2: w.rType.funct = fnAnd;
        3: w.rType.funct = fnOr;
        4: w.rType.funct = fnSlt;
        default: begin
          w.rType.funct = fnSll;
          w.rType.shamt = 5'($urandom_range(0, 31));
        end
      endcase
    end else begin
      w.iType.rs  = ra;
      w.iType.rt  = rb;
      w.iType.imm = 16'($urandom);
      case (pick)
        6: w.iType.opcode = opAddiu;
        7: w.iType.opcode = opAndi;
        8: w.iType.opcode = opOri;
        9: begin
          w.iType.opcode = opLui;
          w.iType.rs     = 5'd0;
        end
        10, 11, 12: begin
          w.iType.opcode = (pick == 12) ? opSw : opLw;
          w.iType.rs     = 5'd0;  // Base r0, offset inside the window
          w.iType.imm    = 16'($urandom_range(0, 63) * 4);
        end
        13, 14: begin
          w.iType.opcode = (pick == 13) ? opBeq : opBne;
          w.iType.imm    = 16'($urandom_range(0, 6));  // Forward skip in words
        end
        default: begin
          w.iType.opcode = opJ;
          tgt = (idx + 1 + $urandom_range(0, 6)) % 256;  // Wraps back to the start
          {w.iType.rs, w.iType.rt, w.iType.imm} = 26'(tgt);
        end
      endcase
    end
    return w;
  endfunction

  function automatic logic [dataWidth-1:0] fillWord(int k);
    return 32'h9E37_79B9 * (32'(k) * 32'd4 + 32'd1);  // Spread over the byte address
  endfunction

  // Instruction slave, 0 to 3 wait cycles
  always @(posedge Clk) begin
    #1;
    if (iAck) begin
      iAck  = 1'b0;  // Master closed the cycle on this edge
      iBusy = 1'b0;
    end else if (iCyc && iStb) begin
      if (!iBusy) begin
        iBusy = 1'b1;
        iWait = $urandom_range(0, 3);
      end
      if (iWait == 0) begin
        iDatI = progMem[iAdr[9:2]];
        iAck  = 1'b1;
      end else begin
        iWait--;
      end
    end
  end

  // Data slave
  always @(posedge Clk) begin
    #1;
    if (dAck) begin
      dAck  = 1'b0;
      dBusy = 1'b0;
    end else if (dCyc && dStb) begin
      if (!dBusy) begin
        dBusy = 1'b1;
        dWait = $urandom_range(0, 3);
      end
      if (dWait == 0) begin
        if (dWe) dataMem[dAdr[7:2]] = dDatO;
        else dDatI = dataMem[dAdr[7:2]];
        dAck = 1'b1;
      end else begin
        dWait--;
      end
    end
  end

  initial begin
    Clk   = 1'b0;
    arstN = 1'b0;
    iDatI = '0;
    iAck  = 1'b0;
    dDatI = '0;
    dAck  = 1'b0;
    iBusy = 1'b0;
    dBusy = 1'b0;
    iWait = 0;
    dWait = 0;
    void'($urandom(68904));
    for (int k = 0; k < 256; k++) progMem[k] = randomInstr(k);
    for (int k = 0; k < 64; k++) dataMem[k] = fillWord(k);
    repeat (2) @(posedge Clk);
    #1 arstN = 1'b1;
    wait (done === 1'b1);
    if (errorCount == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(timeoutNs);
    $display("Pipeline hung: only %0d of %0d commits after %0d ns",
             commitCount, commitTarget, timeoutNs);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== mipsPkg.sv ====
package mipsPkg;

  localparam int dataWidth = 32;  // Machine word and bus width

  // Major opcodes that the core executes
  typedef enum logic [5:0] {
    opSpecial = 6'h00,  // R-type, decoded by funct
    opJ       = 6'h02,
    opBeq     = 6'h04,
    opBne     = 6'h05,
    opAddiu   = 6'h09,
    opAndi    = 6'h0c,
    opOri     = 6'h0d,
    opLui     = 6'h0f,
    opLw      = 6'h23,
    opSw      = 6'h2b
  } opcodeE;

  // Function field of SPECIAL
  typedef enum logic [5:0] {
    fnSll  = 6'h00,
    fnAddu = 6'h21,
    fnSubu = 6'h23,
    fnAnd  = 6'h24,
    fnOr   = 6'h25,
    fnSlt  = 6'h2a
  } functE;

  typedef enum logic [3:0] {
    aluAdd = 4'd0,
    aluSub = 4'd1,
    aluAnd = 4'd2,
    aluOr  = 4'd3,
    aluSlt = 4'd4,  // Signed compare
    aluSll = 4'd5,  // Shift rt by shamt
    aluLui = 4'd6   // Immediate into upper half
  } aluOpE;

  typedef struct packed {
    opcodeE     opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    functE      funct;
  } rTypeS;

  // Low 26 bits double as the J target
  typedef struct packed {
    opcodeE      opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } iTypeS;

  typedef union packed {
    rTypeS rType;
    iTypeS iType;
  } instrU;

  typedef struct packed {
    aluOpE aluOp;
    logic  aluSrc;    // B operand from immediate
    logic  memRead;
    logic  memWrite;
    logic  regWrite;
    logic  branch;
    logic  branchNe;  // BNE rather than BEQ
    logic  jump;
    logic  zeroExt;   // Logical immediates
  } ctrlS;

endpackage

// ==== stageIf.sv ====
`timescale 1ns/1ps

// Fetch to decode
interface fetchDecodeIf import mipsPkg::*; ();
  logic                 valid;
  logic                 ready;
  logic [dataWidth-1:0] pc4;    // Fetch address plus 4
  instrU                instr;
  modport source (output valid, pc4, instr, input ready);
  modport sink (input valid, pc4, instr, output ready);
endinterface

// Decode to execute
interface decodeExecIf import mipsPkg::*; ();
  logic                 valid;
  logic                 ready;
  ctrlS                 ctrl;
  logic [dataWidth-1:0] pc4;
  logic [dataWidth-1:0] rsVal;
  logic [dataWidth-1:0] rtVal;
  logic [dataWidth-1:0] imm;     // Already extended
  logic [4:0]           shamt;
  logic [4:0]           dest;
  logic [dataWidth-1:0] target;  // J target
  modport source (output valid, ctrl, pc4, rsVal, rtVal, imm, shamt, dest, target,
                  input ready);
  modport sink (input valid, ctrl, pc4, rsVal, rtVal, imm, shamt, dest, target,
                output ready);
endinterface

// Execute to memory
interface execMemIf import mipsPkg::*; ();
  logic                 valid;
  logic                 ready;
  ctrlS                 ctrl;
  logic [dataWidth-1:0] result;     // ALU result or load/store address
  logic [dataWidth-1:0] storeData;
  logic [4:0]           dest;
  modport source (output valid, ctrl, result, storeData, dest, input ready);
  modport sink (input valid, ctrl, result, storeData, dest, output ready);
endinterface

// Taken branch or jump, no handshake
interface redirectIf import mipsPkg::*; ();
  logic                 valid;
  logic [dataWidth-1:0] pc;
  modport source (output valid, pc);
  modport sink (input valid, pc);
endinterface
